/* exec_pkg.sv */
package exec_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [XLEN-1:0] addr_t;
	typedef logic [4:0]      reg_idx_t;
	typedef logic [5:0]      ecode_t;

	// One-hot ALU operation, bit positions below
	typedef logic [11:0] alu_op_t;
	localparam int ALU_ADD  = 0;
	localparam int ALU_SUB  = 1;
	localparam int ALU_SLT  = 2;
	localparam int ALU_SLTU = 3;
	localparam int ALU_AND  = 4;
	localparam int ALU_NOR  = 5;
	localparam int ALU_OR   = 6;
	localparam int ALU_XOR  = 7;
	localparam int ALU_SLL  = 8;
	localparam int ALU_SRL  = 9;
	localparam int ALU_SRA  = 10;
	localparam int ALU_LUI  = 11;

	typedef logic [2:0] mul_op_t;
	localparam int MUL_LO = 0;
	localparam int MULH_S = 1;
	localparam int MULH_U = 2;

	// Divide by zero gives quotient all ones, remainder = dividend.
	// Most negative / -1 gives quotient = dividend, remainder = 0.
	typedef logic [3:0] div_op_t;
	localparam int DIV_S = 0;
	localparam int MOD_S = 1;
	localparam int DIV_U = 2;
	localparam int MOD_U = 3;

	// Halfword ops need addr[0] clear, word ops addr[1:0] clear
	typedef logic [7:0] mem_op_t;
	localparam int MEM_LDB  = 0;
	localparam int MEM_LDH  = 1;
	localparam int MEM_LDW  = 2;
	localparam int MEM_STB  = 3;
	localparam int MEM_STH  = 4;
	localparam int MEM_STW  = 5;
	localparam int MEM_LDBU = 6;
	localparam int MEM_LDHU = 7;

	localparam ecode_t ECODE_ALE = 6'h9;

	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_BUSY,
		DIV_DONE
	} div_state_t;

endpackage

/* exec_req_if.sv */
`timescale 1ns/100ps

interface exec_req_if import exec_pkg::*; ();

	logic       valid;
	logic       ready;
	// Multiply ops use the low three bits only
	logic [3:0] op;
	word_t      src1;
	word_t      src2;

	modport issuer (
		output valid,
		output op,
		output src1,
		output src2,
		input  ready
	);

	modport unit (
		input  valid,
		input  op,
		input  src1,
		input  src2,
		output ready
	);

endinterface

/* alu.sv */
`timescale 1ns/100ps

module alu import exec_pkg::*; (
	input  alu_op_t alu_op,
	input  word_t   src1,
	input  word_t   src2,
	output word_t   result
);

	logic          use_sub;
	word_t         adder_b;
	logic [XLEN:0] adder_sum;
	logic          slt;
	logic          sltu;
	logic [4:0]    shamt;
	word_t         sll_res;
	word_t         srl_res;
	word_t         sra_res;

	// Subtract, SLT and SLTU share the adder
	assign use_sub   = alu_op[ALU_SUB] | alu_op[ALU_SLT] | alu_op[ALU_SLTU];
	assign adder_b   = use_sub ? ~src2 : src2;
	assign adder_sum = {1'b0, src1} + {1'b0, adder_b} + {{XLEN{1'b0}}, use_sub};

	assign slt  = (src1[XLEN-1] & ~src2[XLEN-1]) |
		(~(src1[XLEN-1] ^ src2[XLEN-1]) & adder_sum[XLEN-1]);
	// No carry out means a borrow
	assign sltu = ~adder_sum[XLEN];

	assign shamt   = src2[4:0];
	assign sll_res = src1 << shamt;
	assign srl_res = src1 >> shamt;
	assign sra_res = $signed(src1) >>> shamt;

	always_comb begin
		result = '0;
		if (alu_op[ALU_ADD] | alu_op[ALU_SUB])
			result = result | adder_sum[XLEN-1:0];
		if (alu_op[ALU_SLT])
			result = result | {{(XLEN-1){1'b0}}, slt};
		if (alu_op[ALU_SLTU])
			result = result | {{(XLEN-1){1'b0}}, sltu};
		if (alu_op[ALU_AND])
			result = result | (src1 & src2);
		if (alu_op[ALU_NOR])
			result = result | ~(src1 | src2);
		if (alu_op[ALU_OR])
			result = result | (src1 | src2);
		if (alu_op[ALU_XOR])
			result = result | (src1 ^ src2);
		if (alu_op[ALU_SLL])
			result = result | sll_res;
		if (alu_op[ALU_SRL])
			result = result | srl_res;
		if (alu_op[ALU_SRA])
			result = result | sra_res;
		if (alu_op[ALU_LUI])
			result = result | src2;
	end

endmodule

/* ex_stage.sv */
`timescale 1ns/100ps

module ex_stage import exec_pkg::*; #(
	parameter addr_t RESET_PC = 32'h1c000000
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      in_valid,
	output logic      in_ready,
	output logic      out_valid,
	input  logic      out_ready,
	input  logic      flush,
	input  addr_t     pc,
	input  word_t     imm,
	input  word_t     rj_value,
	input  word_t     rkd_value,
	input  alu_op_t   alu_op,
	input  mul_op_t   mul_op,
	input  div_op_t   div_op,
	input  mem_op_t   mem_op,
	input  logic      src1_is_pc,
	input  logic      src2_is_imm,
	input  logic      res_from_mul,
	input  logic      res_from_div,
	input  reg_idx_t  dest,
	input  logic      has_exception,
	input  ecode_t    ecode_in,
	exec_req_if.issuer mul_req,
	exec_req_if.issuer div_req,
	output word_t     alu_result_out,
	output addr_t     pc_out,
	output reg_idx_t  dest_out,
	output logic      has_exception_out,
	output ecode_t    ecode_out,
	output addr_t     badv_out
);

	word_t src1;
	word_t src2;
	word_t alu_result;
	logic  half_op;
	logic  word_op;
	logic  ale;
	logic  kill;
	logic  req_issued;
	logic  ready_go;
	logic  transfer;

	assign src1 = src1_is_pc ? pc : rj_value;
	assign src2 = src2_is_imm ? imm : rkd_value;

	alu i_alu (
		.alu_op (alu_op),
		.src1   (src1),
		.src2   (src2),
		.result (alu_result)
	);

	// Address alignment check on the ALU result
	assign half_op = mem_op[MEM_LDH] | mem_op[MEM_STH] | mem_op[MEM_LDHU];
	assign word_op = mem_op[MEM_LDW] | mem_op[MEM_STW];
	assign ale     = (half_op & alu_result[0]) | (word_op & (|alu_result[1:0]));

	// Flushed or faulting instructions pass straight through
	assign kill = flush | has_exception | ale;

	assign mul_req.valid = in_valid & res_from_mul & ~kill & ~req_issued;
	assign mul_req.op    = {1'b0, mul_op};
	assign mul_req.src1  = src1;
	assign mul_req.src2  = src2;

	assign div_req.valid = in_valid & res_from_div & ~kill & ~req_issued;
	assign div_req.op    = div_op;
	assign div_req.src1  = src1;
	assign div_req.src2  = src2;

	assign ready_go = ~(mul_req.valid & ~mul_req.ready) & ~(div_req.valid & ~div_req.ready);
	assign in_ready = ~rst & (~in_valid | (ready_go & out_ready));
	assign transfer = in_valid & ready_go & out_ready;

	// A unit took the request but the stage is stalled downstream,
	// so the request must not be sent twice
	always_ff @(posedge clk) begin
		if (rst)
			req_issued <= 1'b0;
		else if (transfer)
			req_issued <= 1'b0;
		else if ((mul_req.valid & mul_req.ready) | (div_req.valid & div_req.ready))
			req_issued <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst)
			out_valid <= 1'b0;
		else if (out_ready)
			out_valid <= in_valid & ready_go & ~flush;
	end

	always_ff @(posedge clk) begin
		if (rst)
			pc_out <= RESET_PC;
		else if (transfer)
			pc_out <= pc;
	end

	always_ff @(posedge clk) begin
		if (transfer) begin
			alu_result_out    <= alu_result;
			dest_out          <= dest;
			has_exception_out <= has_exception | ale;
			// Incoming exception wins over ALE
			if (has_exception)
				ecode_out <= ecode_in;
			else if (ale)
				ecode_out <= ECODE_ALE;
			else
				ecode_out <= '0;
			badv_out <= ale ? alu_result : pc;
		end
	end

	a_out_valid_hold: assert property (@(posedge clk) disable iff (rst)
		!out_ready |=> $stable(out_valid));

	a_no_req_on_exc: assert property (@(posedge clk) disable iff (rst)
		in_valid && has_exception |-> !mul_req.valid && !div_req.valid);

endmodule

/* mul_unit.sv */
`timescale 1ns/100ps

module mul_unit import exec_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	exec_req_if.unit req,
	output logic     result_valid,
	output word_t    result
);

	logic                 sext;
	logic                 v1;
	logic                 hi_q;
	logic signed [XLEN:0] a_q;
	logic signed [XLEN:0] b_q;
	logic [2*XLEN+1:0]    product;

	// Fully pipelined, never stalls
	assign req.ready = 1'b1;

	// Low word is the same either way
	assign sext = req.op[MUL_LO] | req.op[MULH_S];

	always_ff @(posedge clk) begin
		if (rst)
			v1 <= 1'b0;
		else
			v1 <= req.valid & req.ready;
	end

	// Stage 1 operands, extended to 33 bits
	always_ff @(posedge clk) begin
		if (req.valid & req.ready) begin
			a_q  <= {sext & req.src1[XLEN-1], req.src1};
			b_q  <= {sext & req.src2[XLEN-1], req.src2};
			hi_q <= req.op[MULH_S] | req.op[MULH_U];
		end
	end

	assign product = a_q * b_q;

	always_ff @(posedge clk) begin
		if (rst)
			result_valid <= 1'b0;
		else
			result_valid <= v1;
	end

	always_ff @(posedge clk) begin
		if (v1)
			result <= hi_q ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];
	end

	a_mul_latency: assert property (@(posedge clk) disable iff (rst)
		req.valid && req.ready |-> ##2 result_valid);

endmodule

/* div_unit.sv */
`timescale 1ns/100ps

module div_unit import exec_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	exec_req_if.unit req,
	output logic     result_valid,
	output word_t    result
);

	div_state_t    state;
	logic          is_signed;
	logic          neg_a;
	logic          neg_b;
	word_t         abs_a;
	word_t         abs_b;
	word_t         quo;
	word_t         rem;
	word_t         den;
	logic [4:0]    cnt;
	logic          neg_q;
	logic          neg_r;
	logic          sel_quo;
	logic [XLEN:0] shifted;
	logic [XLEN:0] diff;

	assign req.ready = (state == DIV_IDLE);

	assign is_signed = req.op[DIV_S] | req.op[MOD_S];
	assign neg_a     = is_signed & req.src1[XLEN-1];
	assign neg_b     = is_signed & req.src2[XLEN-1];
	assign abs_a     = neg_a ? -req.src1 : req.src1;
	assign abs_b     = neg_b ? -req.src2 : req.src2;

	// Restoring step, borrow shows in the top bit
	assign shifted = {rem, quo[XLEN-1]};
	assign diff    = shifted - {1'b0, den};

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= DIV_IDLE;
		end else begin
			case (state)
				DIV_IDLE: begin
					if (req.valid) begin
						sel_quo <= req.op[DIV_S] | req.op[DIV_U];
						cnt     <= '0;
						den     <= abs_b;
						if (req.src2 == '0) begin
							quo   <= '1;
							rem   <= req.src1;
							neg_q <= 1'b0;
							neg_r <= 1'b0;
							state <= DIV_DONE;
						end else if (is_signed && req.src1 == {1'b1, {(XLEN-1){1'b0}}} &&
							req.src2 == '1) begin
							quo   <= req.src1;
							rem   <= '0;
							neg_q <= 1'b0;
							neg_r <= 1'b0;
							state <= DIV_DONE;
						end else begin
							quo   <= abs_a;
							rem   <= '0;
							neg_q <= neg_a ^ neg_b;
							neg_r <= neg_a;
							state <= DIV_BUSY;
						end
					end
				end
				DIV_BUSY: begin
					if (diff[XLEN]) begin
						rem <= shifted[XLEN-1:0];
						quo <= {quo[XLEN-2:0], 1'b0};
					end else begin
						rem <= diff[XLEN-1:0];
						quo <= {quo[XLEN-2:0], 1'b1};
					end
					cnt <= cnt + 5'd1;
					if (cnt == 5'd31)
						state <= DIV_DONE;
				end
				default: state <= DIV_IDLE;
			endcase
		end
	end

	assign result_valid = (state == DIV_DONE);
	assign result = sel_quo ? (neg_q ? -quo : quo) : (neg_r ? -rem : rem);

	// Partial remainder stays below the divisor on every step
	a_rem_below_den: assert property (@(posedge clk) disable iff (rst)
		state == DIV_BUSY |-> rem < den);

endmodule

/* exec_top.sv */
`timescale 1ns/100ps

module exec_top import exec_pkg::*; #(
	parameter addr_t RESET_PC = 32'h1c000000
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid,
	output logic     in_ready,
	output logic     out_valid,
	input  logic     out_ready,
	input  logic     flush,
	input  addr_t    pc,
	input  word_t    imm,
	input  word_t    rj_value,
	input  word_t    rkd_value,
	input  alu_op_t  alu_op,
	input  mul_op_t  mul_op,
	input  div_op_t  div_op,
	input  mem_op_t  mem_op,
	input  logic     src1_is_pc,
	input  logic     src2_is_imm,
	input  logic     res_from_mul,
	input  logic     res_from_div,
	input  reg_idx_t dest,
	input  logic     has_exception,
	input  ecode_t   ecode_in,
	output word_t    alu_result_out,
	output addr_t    pc_out,
	output reg_idx_t dest_out,
	output logic     has_exception_out,
	output ecode_t   ecode_out,
	output addr_t    badv_out,
	output logic     mul_result_valid,
	output word_t    mul_result,
	output logic     div_result_valid,
	output word_t    div_result
);

	exec_req_if mul_req ();
	exec_req_if div_req ();

	ex_stage #(
		.RESET_PC (RESET_PC)
	) i_ex_stage (
		.clk               (clk),
		.rst               (rst),
		.in_valid          (in_valid),
		.in_ready          (in_ready),
		.out_valid         (out_valid),
		.out_ready         (out_ready),
		.flush             (flush),
		.pc                (pc),
		.imm               (imm),
		.rj_value          (rj_value),
		.rkd_value         (rkd_value),
		.alu_op            (alu_op),
		.mul_op            (mul_op),
		.div_op            (div_op),
		.mem_op            (mem_op),
		.src1_is_pc        (src1_is_pc),
		.src2_is_imm       (src2_is_imm),
		.res_from_mul      (res_from_mul),
		.res_from_div      (res_from_div),
		.dest              (dest),
		.has_exception     (has_exception),
		.ecode_in          (ecode_in),
		.mul_req           (mul_req),
		.div_req           (div_req),
		.alu_result_out    (alu_result_out),
		.pc_out            (pc_out),
		.dest_out          (dest_out),
		.has_exception_out (has_exception_out),
		.ecode_out         (ecode_out),
		.badv_out          (badv_out)
	);

	mul_unit i_mul_unit (
		.clk          (clk),
		.rst          (rst),
		.req          (mul_req),
		.result_valid (mul_result_valid),
		.result       (mul_result)
	);

	div_unit i_div_unit (
		.clk          (clk),
		.rst          (rst),
		.req          (div_req),
		.result_valid (div_result_valid),
		.result       (div_result)
	);

endmodule

/* tb_exec_top.sv */
`timescale 1ns/100ps

module tb_exec_top import exec_pkg::*; ();

	localparam addr_t RESET_PC = 32'h1c000000;

	logic     clk;
	logic     rst;
	logic     in_valid;
	logic     in_ready;
	logic     out_valid;
	logic     out_ready;
	logic     flush;
	addr_t    pc;
	word_t    imm;
	word_t    rj_value;
	word_t    rkd_value;
	alu_op_t  alu_op;
	mul_op_t  mul_op;
	div_op_t  div_op;
	mem_op_t  mem_op;
	logic     src1_is_pc;
	logic     src2_is_imm;
	logic     res_from_mul;
	logic     res_from_div;
	reg_idx_t dest;
	logic     has_exception;
	ecode_t   ecode_in;
	word_t    alu_result_out;
	addr_t    pc_out;
	reg_idx_t dest_out;
	logic     has_exception_out;
	ecode_t   ecode_out;
	addr_t    badv_out;
	logic     mul_result_valid;
	word_t    mul_result;
	logic     div_result_valid;
	word_t    div_result;

	int    seed;
	int    value_errors;
	int    timeouts;
	int    assert_errors = 0;
	int    k;
	int    sel;
	int    lo;
	word_t a;
	word_t b;
	word_t expected;
	word_t held;

	exec_top #(
		.RESET_PC (RESET_PC)
	) i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	a_reset_ready: assert property (@(posedge clk) rst |-> !in_ready)
		else begin
			assert_errors++;
			$display("in_ready was high during reset");
		end

	a_reset_state: assert property (@(posedge clk) rst |=> !out_valid && !mul_result_valid &&
		!div_result_valid && pc_out == RESET_PC)
		else begin
			assert_errors++;
			$display("DUT left a reset cycle with a valid output or a wrong pc_out");
		end

	function automatic word_t alu_model(input int op, input word_t x, input word_t y);
		case (op)
			ALU_ADD:  return x + y;
			ALU_SUB:  return x - y;
			ALU_SLT:  return {31'b0, $signed(x) < $signed(y)};
			ALU_SLTU: return {31'b0, x < y};
			ALU_AND:  return x & y;
			ALU_NOR:  return ~(x | y);
			ALU_OR:   return x | y;
			ALU_XOR:  return x ^ y;
			ALU_SLL:  return x << y[4:0];
			ALU_SRL:  return x >> y[4:0];
			ALU_SRA:  return $signed(x) >>> y[4:0];
			default:  return y;
		endcase
	endfunction

	function automatic word_t mul_model(input int op, input word_t x, input word_t y);
		logic [63:0] p;
		// Low 64 bits of the extended product give the signed result too
		if (op == MULH_S)
			p = {{32{x[31]}}, x} * {{32{y[31]}}, y};
		else
			p = {32'b0, x} * {32'b0, y};
		return (op == MUL_LO) ? p[31:0] : p[63:32];
	endfunction

	function automatic word_t div_model(input int op, input word_t x, input word_t y);
		word_t q;
		word_t r;
		logic  sgn;
		sgn = (op == DIV_S) || (op == MOD_S);
		if (y == '0) begin
			q = '1;
			r = x;
		end else if (sgn && x == 32'h80000000 && y == 32'hffffffff) begin
			q = x;
			r = '0;
		end else if (sgn) begin
			q = $signed(x) / $signed(y);
			r = $signed(x) % $signed(y);
		end else begin
			q = x / y;
			r = x % y;
		end
		return (op == DIV_S || op == DIV_U) ? q : r;
	endfunction

	task automatic compare_value(input string name, input word_t exp_val, input word_t act_val);
		assert (act_val === exp_val)
		else begin
			value_errors++;
			$display("FAIL %s: expected %h, actual %h", name, exp_val, act_val);
		end
	endtask

	task automatic clear_inputs();
		in_valid = 1'b0;
		flush = 1'b0;
		pc = '0;
		imm = '0;
		rj_value = '0;
		rkd_value = '0;
		alu_op = '0;
		mul_op = '0;
		div_op = '0;
		mem_op = '0;
		src1_is_pc = 1'b0;
		src2_is_imm = 1'b0;
		res_from_mul = 1'b0;
		res_from_div = 1'b0;
		dest = '0;
		has_exception = 1'b0;
		ecode_in = '0;
	endtask

	// Called at a falling edge, returns just before the accepting edge
	task automatic wait_ready(input string what);
		int n;
		n = 0;
		#1;
		while (!in_ready && n < 40) begin
			@(negedge clk);
			#1;
			n++;
		end
		if (!in_ready) begin
			timeouts++;
			$display("Timeout: the %s instruction was not accepted within 40 cycles", what);
		end
	endtask

	task automatic transfer_one(input string what);
		in_valid = 1'b1;
		wait_ready(what);
		@(posedge clk);
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic run_mem(input int m, input word_t addr, input logic exc);
		logic half;
		logic word;
		logic bad;
		half = (m == MEM_LDH) || (m == MEM_STH) || (m == MEM_LDHU);
		word = (m == MEM_LDW) || (m == MEM_STW);
		bad = (half && addr[0]) || (word && addr[1:0] != 2'b00);
		clear_inputs();
		mem_op = 8'b1 << m;
		alu_op = 12'b1 << ALU_ADD;
		rj_value = addr - 32'd16;
		imm = 32'd16;
		src2_is_imm = 1'b1;
		has_exception = exc;
		ecode_in = 6'h3;
		transfer_one("memory");
		compare_value("mem exception", {31'b0, exc | bad}, {31'b0, has_exception_out});
		if (exc) begin
			compare_value("mem ecode kept", 32'h3, {26'b0, ecode_out});
		end else if (bad) begin
			compare_value("mem ecode ale", 32'h9, {26'b0, ecode_out});
			compare_value("mem badv", addr, badv_out);
		end
	endtask

	task automatic run_mul_pair(input int k0, input int k1);
		word_t exp0;
		word_t exp1;
		clear_inputs();
		res_from_mul = 1'b1;
		mul_op = 3'b1 << k0;
		rj_value = $random(seed);
		rkd_value = $random(seed);
		exp0 = mul_model(k0, rj_value, rkd_value);
		in_valid = 1'b1;
		wait_ready("first multiply");
		@(posedge clk);
		@(negedge clk);
		compare_value("mul valid early", 32'd0, {31'b0, mul_result_valid});
		mul_op = 3'b1 << k1;
		rj_value = $random(seed);
		rkd_value = $random(seed);
		exp1 = mul_model(k1, rj_value, rkd_value);
		wait_ready("second multiply");
		@(posedge clk);
		@(negedge clk);
		in_valid = 1'b0;
		compare_value("mul valid first", 32'd1, {31'b0, mul_result_valid});
		compare_value($sformatf("mul op %0d", k0), exp0, mul_result);
		@(posedge clk);
		@(negedge clk);
		compare_value("mul valid second", 32'd1, {31'b0, mul_result_valid});
		compare_value($sformatf("mul op %0d", k1), exp1, mul_result);
		@(posedge clk);
		@(negedge clk);
		compare_value("mul valid after", 32'd0, {31'b0, mul_result_valid});
	endtask

	task automatic run_div(input int op, input word_t x, input word_t y);
		word_t exp_val;
		int    n;
		exp_val = div_model(op, x, y);
		clear_inputs();
		res_from_div = 1'b1;
		div_op = 4'b1 << op;
		rj_value = x;
		rkd_value = y;
		in_valid = 1'b1;
		wait_ready("divide");
		@(posedge clk);
		@(negedge clk);
		// Same instruction stays offered, the busy divider must stall it
		n = 0;
		#1;
		while (!div_result_valid && n < 40) begin
			compare_value("div in_ready pending", 32'd0, {31'b0, in_ready});
			@(negedge clk);
			#1;
			n++;
		end
		if (!div_result_valid) begin
			timeouts++;
			$display("Timeout: no divide result within 40 cycles for op %0d", op);
		end else begin
			compare_value($sformatf("div op %0d %h/%h", op, x, y), exp_val, div_result);
		end
		@(posedge clk);
		@(negedge clk);
		in_valid = 1'b0;
		res_from_div = 1'b0;
	endtask

	initial begin
		seed = 32'hc756;
		value_errors = 0;
		timeouts = 0;
		rst = 1'b1;
		out_ready = 1'b1;
		clear_inputs();
		repeat (8) @(negedge clk);
		rst = 1'b0;

		compare_value("reset out_valid", 32'd0, {31'b0, out_valid});
		compare_value("reset mul valid", 32'd0, {31'b0, mul_result_valid});
		compare_value("reset div valid", 32'd0, {31'b0, div_result_valid});
		compare_value("reset pc_out", RESET_PC, pc_out);

		for (k = 0; k < 12; k++) begin
			for (sel = 0; sel < 4; sel++) begin
				clear_inputs();
				pc = $random(seed);
				imm = $random(seed);
				rj_value = $random(seed);
				rkd_value = $random(seed);
				dest = reg_idx_t'($random(seed));
				src1_is_pc = sel[0];
				src2_is_imm = sel[1];
				alu_op = 12'b1 << k;
				expected = alu_model(k, sel[0] ? pc : rj_value, sel[1] ? imm : rkd_value);
				a = pc;
				transfer_one("alu");
				compare_value("alu out_valid", 32'd1, {31'b0, out_valid});
				compare_value($sformatf("alu op %0d sel %0d", k, sel), expected, alu_result_out);
				compare_value("alu pc_out", a, pc_out);
				compare_value("alu dest_out", {27'b0, dest}, {27'b0, dest_out});
			end
		end

		for (k = 0; k < 8; k++) begin
			for (lo = 0; lo < 4; lo++) begin
				a = $random(seed);
				a[1:0] = lo[1:0];
				run_mem(k, a, 1'b0);
			end
		end
		a = $random(seed);
		run_mem(MEM_LDW, a | 32'd2, 1'b1);
		run_mem(MEM_LDH, a | 32'd1, 1'b1);

		for (k = 0; k < 3; k++)
			run_mul_pair(k, (k + 1) % 3);

		for (k = 0; k < 4; k++) begin
			run_div(k, $random(seed), $random(seed));
			a = $random(seed);
			b = $random(seed);
			// Small divisor so the quotient has many bits
			b = {{20{b[11]}}, b[11:0]};
			run_div(k, a, b);
			run_div(k, $random(seed), '0);
		end
		run_div(DIV_S, 32'h80000000, 32'hffffffff);
		run_div(MOD_S, 32'h80000000, 32'hffffffff);

		// Back-pressure
		clear_inputs();
		rj_value = $random(seed);
		rkd_value = $random(seed);
		alu_op = 12'b1 << ALU_XOR;
		held = alu_model(ALU_XOR, rj_value, rkd_value);
		transfer_one("held");
		compare_value("hold out_valid", 32'd1, {31'b0, out_valid});
		compare_value("hold first result", held, alu_result_out);
		out_ready = 1'b0;
		rj_value = $random(seed);
		alu_op = 12'b1 << ALU_ADD;
		in_valid = 1'b1;
		repeat (3) begin
			#1;
			compare_value("hold in_ready", 32'd0, {31'b0, in_ready});
			@(posedge clk);
			@(negedge clk);
			compare_value("hold out_valid", 32'd1, {31'b0, out_valid});
			compare_value("hold result", held, alu_result_out);
		end
		out_ready = 1'b1;
		expected = rj_value + rkd_value;
		wait_ready("stalled");
		@(posedge clk);
		@(negedge clk);
		in_valid = 1'b0;
		compare_value("release out_valid", 32'd1, {31'b0, out_valid});
		compare_value("release result", expected, alu_result_out);

		// Flushed multiply never shows up
		clear_inputs();
		res_from_mul = 1'b1;
		mul_op = 3'b1 << MUL_LO;
		flush = 1'b1;
		transfer_one("flushed");
		clear_inputs();
		repeat (3) begin
			compare_value("flush out_valid", 32'd0, {31'b0, out_valid});
			compare_value("flush mul valid", 32'd0, {31'b0, mul_result_valid});
			@(posedge clk);
			@(negedge clk);
		end

		$display("Errors: %0d value, %0d timeout, %0d assertion",
			value_errors, timeouts, assert_errors);
		if (value_errors == 0 && timeouts == 0 && assert_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* compile.f */
exec_pkg.sv
exec_req_if.sv
alu.sv
ex_stage.sv
mul_unit.sv
div_unit.sv
exec_top.sv
tb_exec_top.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_exec_top
FILELIST  = compile.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
